//--- tb.f
common/exPkg.sv
src/operandForward.sv
src/aluCore.sv
src/branchUnit.sv
src/exMemReg.sv
src/exUnit.sv
tb/tbExUnit.sv

//--- Makefile
TOP = tbExUnit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tbExUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tbExUnit;

    logic                clk;
    logic                reset;
    logic                inValid;
    logic                inReady;
    exPkg::idExBundle_t  inBundle;
    logic                flush;
    logic                wbRegWrite;
    exPkg::regIdx_t      wbRd;
    exPkg::word_t        wbData;
    logic                outValid;
    logic                outReady;
    exPkg::exMemBundle_t outBundle;

    // Model copy of the item that forwarding sees in EX/MEM
    exPkg::exMemBundle_t heldModel;
    logic                heldModelValid;
    int                  passCount = 0;
    int                  failCount = 0;
    int                  cycleCount = 0;

    exUnit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // The tests need a few hundred cycles at most
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= 2000) begin
            $display("Timeout: the run did not finish within 2000 cycles");
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic exPkg::word_t modelForward(exPkg::regIdx_t idx, exPkg::word_t rfData);
        if (idx != 5'd0 && heldModelValid && heldModel.regWrite && heldModel.rd == idx)
            return heldModel.aluResult;
        if (idx != 5'd0 && wbRegWrite && wbRd == idx)
            return wbData;
        return rfData;
    endfunction

    function automatic exPkg::word_t modelAlu(exPkg::aluOp_t op, exPkg::word_t a,
                                              exPkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            exPkg::ALU_ADD:  return a + b;
            exPkg::ALU_SUB:  return a + ~b + 32'd1;
            exPkg::ALU_AND:  return a & b;
            exPkg::ALU_OR:   return a | b;
            exPkg::ALU_XOR:  return a ^ b;
            exPkg::ALU_SLL:  return a << sh;
            exPkg::ALU_SRL:  return a >> sh;
            exPkg::ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            // Signed order by flipping both sign bits
            exPkg::ALU_SLT:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            exPkg::ALU_SLTU: return {31'd0, a < b};
            default:         return 32'd0;
        endcase
    endfunction

    function automatic logic modelTaken(exPkg::branchOp_t op, exPkg::word_t a, exPkg::word_t b);
        logic lt;
        lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            exPkg::BR_EQ:  return a == b;
            exPkg::BR_NE:  return a != b;
            exPkg::BR_LT:  return lt;
            exPkg::BR_GE:  return !lt;
            exPkg::BR_LTU: return a < b;
            exPkg::BR_GEU: return a >= b;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic exPkg::exMemBundle_t modelResult(exPkg::idExBundle_t item, logic fl);
        exPkg::exMemBundle_t res;
        exPkg::word_t        a;
        exPkg::word_t        b;
        a = modelForward(item.rs1, item.rs1Data);
        b = modelForward(item.rs2, item.rs2Data);
        res.aluResult = modelAlu(item.aluOp, a, item.aluSrcImm ? item.imm : b);
        res.storeData = b;
        res.target    = item.pc + item.imm + item.imm;
        res.rd        = item.rd;
        res.regWrite  = item.regWrite && !fl;
        res.memRead   = item.memRead && !fl;
        res.memWrite  = item.memWrite && !fl;
        res.redirect  = modelTaken(item.branchOp, a, b) && !fl;
        return res;
    endfunction

    function automatic string fieldName(logic differs, string name);
        return differs ? name : "";
    endfunction

    task automatic checkResult(exPkg::exMemBundle_t expected, exPkg::exMemBundle_t actual);
        string diff;
        if (actual === expected) begin
            passCount++;
        end else begin
            failCount++;
            diff = {fieldName(actual.aluResult !== expected.aluResult, " aluResult"),
                    fieldName(actual.storeData !== expected.storeData, " storeData"),
                    fieldName(actual.target !== expected.target, " target"),
                    fieldName(actual.rd !== expected.rd, " rd"),
                    fieldName(actual.regWrite !== expected.regWrite, " regWrite"),
                    fieldName(actual.memRead !== expected.memRead, " memRead"),
                    fieldName(actual.memWrite !== expected.memWrite, " memWrite"),
                    fieldName(actual.redirect !== expected.redirect, " redirect")};
            $display("Error at %0t: outBundle differs in%s, expected %h got %h", $time,
                     diff, expected, actual);
        end
    endtask

    task automatic checkReady(logic expInReady, logic expOutValid);
        if (inReady === expInReady && outValid === expOutValid) begin
            passCount++;
        end else begin
            failCount++;
            $display("Error at %0t: inReady %b outValid %b, expected %b %b", $time,
                     inReady, outValid, expInReady, expOutValid);
        end
    endtask

    function automatic exPkg::idExBundle_t makeItem(exPkg::aluOp_t op, exPkg::regIdx_t rs1,
                                                    exPkg::regIdx_t rs2, exPkg::regIdx_t rd);
        exPkg::idExBundle_t item;
        item          = '0;
        item.pc       = $urandom & 32'hffff_fffc;
        item.rs1Data  = $urandom;
        item.rs2Data  = $urandom;
        item.imm      = $urandom;
        item.rs1      = rs1;
        item.rs2      = rs2;
        item.rd       = rd;
        item.aluOp    = op;
        item.regWrite = 1'b1;
        return item;
    endfunction

    // Starts and ends on a falling edge, so items can follow back to back
    task automatic sendItem(exPkg::idExBundle_t item, logic fl);
        exPkg::exMemBundle_t expected;
        inBundle = item;
        flush    = fl;
        inValid  = 1'b1;
        while (!inReady) begin
            @(negedge clk);
        end
        expected = modelResult(item, fl);
        @(negedge clk);
        if (!outValid) begin
            failCount++;
            $display("Output missing: outValid did not rise one cycle after acceptance (%0t)",
                     $time);
        end
        checkResult(expected, outBundle);
        heldModel      = expected;
        heldModelValid = 1'b1;
        inValid        = 1'b0;
        flush          = 1'b0;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        heldModelValid = 1'b0;
    endtask

    task automatic sendImm(exPkg::aluOp_t op, exPkg::word_t imm);
        exPkg::idExBundle_t item;
        item           = makeItem(op, 5'd3, 5'd4, 5'd20);
        item.aluSrcImm = 1'b1;
        item.imm       = imm;
        sendItem(item, 1'b0);
    endtask

    task automatic reportTest(string name, int startFails);
        $display("Test %s finished with %0d errors", name, failCount - startFails);
    endtask

    task automatic testAluOps();
        int startFails;
        startFails = failCount;
        for (int i = 0; i < 30; i++) begin
            // Destinations x10 to x19 never match the sources
            sendItem(makeItem(exPkg::aluOp_t'(i % 10), 5'd1, 5'd2, 5'(10 + i % 10)), 1'b0);
        end
        idleCycle();
        reportTest("aluOps", startFails);
    endtask

    task automatic testImmediate();
        int startFails;
        startFails = failCount;
        sendImm(exPkg::ALU_ADD, 32'd100);
        sendImm(exPkg::ALU_ADD, 32'hffff_fffb);
        sendImm(exPkg::ALU_SLL, 32'd4);
        sendImm(exPkg::ALU_SRA, 32'h0000_0023);
        sendImm(exPkg::ALU_SLT, 32'hffff_ffff);
        sendImm(exPkg::ALU_SLTU, 32'hffff_ffff);
        sendImm(exPkg::ALU_SLT, 32'h0000_07ff);
        idleCycle();
        reportTest("immediate", startFails);
    endtask

    task automatic testForwarding();
        exPkg::idExBundle_t item;
        int                 startFails;
        startFails = failCount;
        sendItem(makeItem(exPkg::ALU_ADD, 5'd1, 5'd2, 5'd5), 1'b0);
        sendItem(makeItem(exPkg::ALU_SUB, 5'd5, 5'd5, 5'd7), 1'b0);
        // Held rd is x7, so x6 comes from write-back
        wbRegWrite = 1'b1;
        wbRd       = 5'd6;
        wbData     = $urandom;
        sendItem(makeItem(exPkg::ALU_XOR, 5'd6, 5'd3, 5'd8), 1'b0);
        // Both sources hold x8 and EX/MEM is the newer one
        wbRd = 5'd8;
        sendItem(makeItem(exPkg::ALU_OR, 5'd8, 5'd8, 5'd9), 1'b0);
        item          = makeItem(exPkg::ALU_AND, 5'd1, 5'd2, 5'd12);
        item.regWrite = 1'b0;
        sendItem(item, 1'b0);
        sendItem(makeItem(exPkg::ALU_ADD, 5'd12, 5'd12, 5'd0), 1'b0);
        wbRd = 5'd0;
        sendItem(makeItem(exPkg::ALU_ADD, 5'd0, 5'd0, 5'd13), 1'b0);
        wbRegWrite = 1'b0;
        idleCycle();
        reportTest("forwarding", startFails);
    endtask

    task automatic testBranches();
        exPkg::idExBundle_t item;
        exPkg::word_t       pairA [4] = '{32'd5, 32'hffff_fffd, 32'd4, 32'd1};
        exPkg::word_t       pairB [4] = '{32'd5, 32'd4, 32'hffff_fffd, 32'd2};
        int                 startFails;
        startFails = failCount;
        for (int op = 0; op < 7; op++) begin
            for (int k = 0; k < 4; k++) begin
                item          = makeItem(exPkg::ALU_ADD, 5'd3, 5'd4, 5'd0);
                item.branchOp = exPkg::branchOp_t'(op);
                item.regWrite = 1'b0;
                item.rs1Data  = pairA[k];
                item.rs2Data  = pairB[k];
                // Small signed halfword offset
                item.imm      = {{20{item.imm[11]}}, item.imm[11:0]};
                sendItem(item, 1'b0);
            end
        end
        idleCycle();
        reportTest("branches", startFails);
    endtask

    task automatic testFlush();
        exPkg::idExBundle_t item;
        int                 startFails;
        startFails = failCount;
        item          = makeItem(exPkg::ALU_ADD, 5'd1, 5'd2, 5'd9);
        item.memRead  = 1'b1;
        item.memWrite = 1'b1;
        item.branchOp = exPkg::BR_EQ;
        item.rs2Data  = item.rs1Data;
        sendItem(item, 1'b1);
        // Reads x9 right behind the killed writer
        sendItem(makeItem(exPkg::ALU_ADD, 5'd9, 5'd9, 5'd10), 1'b0);
        idleCycle();
        reportTest("flush", startFails);
    endtask

    task automatic testBackPressure();
        exPkg::idExBundle_t  first;
        exPkg::idExBundle_t  second;
        exPkg::exMemBundle_t expFirst;
        exPkg::exMemBundle_t expSecond;
        int                  startFails;
        startFails = failCount;
        first    = makeItem(exPkg::ALU_SLL, 5'd1, 5'd2, 5'd11);
        second   = makeItem(exPkg::ALU_ADD, 5'd11, 5'd3, 5'd14);
        outReady = 1'b0;
        checkReady(1'b1, 1'b0);
        inBundle = first;
        inValid  = 1'b1;
        expFirst = modelResult(first, 1'b0);
        @(negedge clk);
        heldModel      = expFirst;
        heldModelValid = 1'b1;
        // Second item waits behind the stalled first one
        inBundle = second;
        repeat (5) begin
            checkReady(1'b0, 1'b1);
            checkResult(expFirst, outBundle);
            @(negedge clk);
        end
        expSecond = modelResult(second, 1'b0);
        outReady  = 1'b1;
        @(negedge clk);
        checkReady(1'b1, 1'b1);
        checkResult(expSecond, outBundle);
        inValid   = 1'b0;
        heldModel = expSecond;
        idleCycle();
        reportTest("backPressure", startFails);
    endtask

    initial begin
        void'($urandom(32'hf664520a));
        reset          = 1'b1;
        inValid        = 1'b0;
        inBundle       = '0;
        flush          = 1'b0;
        wbRegWrite     = 1'b0;
        wbRd           = '0;
        wbData         = '0;
        outReady       = 1'b1;
        heldModel      = '0;
        heldModelValid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkReady(1'b1, 1'b0);
        testAluOps();
        testImmediate();
        testForwarding();
        testBranches();
        testFlush();
        testBackPressure();
        $display("Summary: %0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exUnit.sv
`timescale 1ns/100ps
`default_nettype none

module exUnit (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                inValid,
    output logic                     inReady,
    input  wire exPkg::idExBundle_t  inBundle,
    input  wire logic                flush,
    input  wire logic                wbRegWrite,
    input  wire exPkg::regIdx_t      wbRd,
    input  wire exPkg::word_t        wbData,
    output logic                     outValid,
    input  wire logic                outReady,
    output exPkg::exMemBundle_t      outBundle
);

    // Forwarded operands
    exPkg::word_t opA;
    exPkg::word_t opB;
    exPkg::word_t cmpA;
    exPkg::word_t cmpB;
    exPkg::word_t storeData;

    // Results for the register
    exPkg::word_t aluResult;
    exPkg::word_t target;
    logic         taken;

    // Held EX/MEM item feeds back as a forwarding source
    operandForward fwdInst (
        .inBundle   (inBundle),
        .heldBundle (outBundle),
        .heldValid  (outValid),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .opA        (opA),
        .opB        (opB),
        .cmpA       (cmpA),
        .cmpB       (cmpB),
        .storeData  (storeData)
    );

    aluCore aluInst (
        .opA       (opA),
        .opB       (opB),
        .aluOp     (inBundle.aluOp),
        .aluResult (aluResult)
    );

    branchUnit branchInst (
        .cmpA     (cmpA),
        .cmpB     (cmpB),
        .pc       (inBundle.pc),
        .imm      (inBundle.imm),
        .branchOp (inBundle.branchOp),
        .taken    (taken),
        .target   (target)
    );

    exMemReg regInst (
        .clk       (clk),
        .reset     (reset),
        .inValid   (inValid),
        .inBundle  (inBundle),
        .flush     (flush),
        .aluResult (aluResult),
        .storeData (storeData),
        .target    (target),
        .taken     (taken),
        .outReady  (outReady),
        .inReady   (inReady),
        .outValid  (outValid),
        .outBundle (outBundle)
    );

endmodule

`default_nettype wire

//--- src/exMemReg.sv
`timescale 1ns/100ps
`default_nettype none

module exMemReg (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               inValid,
    input  wire exPkg::idExBundle_t inBundle,
    input  wire logic               flush,
    input  wire exPkg::word_t       aluResult,
    input  wire exPkg::word_t       storeData,
    input  wire exPkg::word_t       target,
    input  wire logic               taken,
    input  wire logic               outReady,
    output logic                    inReady,
    output logic                    outValid,
    output exPkg::exMemBundle_t     outBundle
);

    exPkg::exMemBundle_t merged;
    logic                accept;

    // Room when empty or when the held item leaves this edge
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_comb begin
        merged.aluResult = aluResult;
        merged.storeData = storeData;
        merged.target    = target;
        merged.rd        = inBundle.rd;
        // A flushed item keeps its data but loses all side effects
        merged.regWrite  = inBundle.regWrite && !flush;
        merged.memRead   = inBundle.memRead && !flush;
        merged.memWrite  = inBundle.memWrite && !flush;
        merged.redirect  = taken && !flush;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid           <= 1'b0;
            outBundle.regWrite <= 1'b0;
            outBundle.memRead  <= 1'b0;
            outBundle.memWrite <= 1'b0;
            outBundle.redirect <= 1'b0;
        end else begin
            if (inReady) begin
                outValid <= inValid;
            end
            if (accept) begin
                outBundle <= merged;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/branchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  wire exPkg::word_t     cmpA,
    input  wire exPkg::word_t     cmpB,
    input  wire exPkg::word_t     pc,
    input  wire exPkg::word_t     imm,
    input  wire exPkg::branchOp_t branchOp,
    output logic                  taken,
    output exPkg::word_t          target
);

    logic isEqual;
    logic isLessSigned;
    logic isLessUnsigned;

    assign isEqual        = (cmpA == cmpB);
    assign isLessSigned   = ($signed(cmpA) < $signed(cmpB));
    assign isLessUnsigned = (cmpA < cmpB);

    // Decision per compare condition
    always_comb begin
        case (branchOp)
            exPkg::BR_EQ:  taken = isEqual;
            exPkg::BR_NE:  taken = !isEqual;
            exPkg::BR_LT:  taken = isLessSigned;
            exPkg::BR_GE:  taken = !isLessSigned;
            exPkg::BR_LTU: taken = isLessUnsigned;
            exPkg::BR_GEU: taken = !isLessUnsigned;
            default:       taken = 1'b0;
        endcase
    end

    // Halfword offset from the decoder, so scale it by two
    assign target = pc + (imm << 1);

endmodule

`default_nettype wire

//--- src/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

module aluCore (
    input  wire exPkg::word_t  opA,
    input  wire exPkg::word_t  opB,
    input  wire exPkg::aluOp_t aluOp,
    output exPkg::word_t       aluResult
);

    logic [4:0] shamt;

    // Only the low five bits count for a 32-bit shift
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            exPkg::ALU_ADD: begin
                aluResult = opA + opB;
            end
            exPkg::ALU_SUB: begin
                aluResult = opA - opB;
            end
            exPkg::ALU_AND: begin
                aluResult = opA & opB;
            end
            exPkg::ALU_OR: begin
                aluResult = opA | opB;
            end
            exPkg::ALU_XOR: begin
                aluResult = opA ^ opB;
            end
            exPkg::ALU_SLL: begin
                aluResult = opA << shamt;
            end
            exPkg::ALU_SRL: begin
                aluResult = opA >> shamt;
            end
            exPkg::ALU_SRA: begin
                aluResult = $signed(opA) >>> shamt;
            end
            exPkg::ALU_SLT: begin
                aluResult = {31'd0, $signed(opA) < $signed(opB)};
            end
            exPkg::ALU_SLTU: begin
                aluResult = {31'd0, opA < opB};
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/operandForward.sv
`timescale 1ns/100ps
`default_nettype none

module operandForward (
    input  wire exPkg::idExBundle_t  inBundle,
    input  wire exPkg::exMemBundle_t heldBundle,
    input  wire logic                heldValid,
    input  wire logic                wbRegWrite,
    input  wire exPkg::regIdx_t      wbRd,
    input  wire exPkg::word_t        wbData,
    output exPkg::word_t             opA,
    output exPkg::word_t             opB,
    output exPkg::word_t             cmpA,
    output exPkg::word_t             cmpB,
    output exPkg::word_t             storeData
);

    exPkg::word_t fwdRs1;
    exPkg::word_t fwdRs2;

    // Priority is EX/MEM first, then write-back, then register file
    function automatic exPkg::word_t forwardOperand(
        input exPkg::regIdx_t      idx,
        input exPkg::word_t        rfData,
        input exPkg::exMemBundle_t held,
        input logic                heldOk,
        input logic                wbWrite,
        input exPkg::regIdx_t      wbIdx,
        input exPkg::word_t        wbValue
    );
        if (idx == '0)
            return rfData;
        if (heldOk && held.regWrite && (held.rd == idx))
            return held.aluResult;
        if (wbWrite && (wbIdx == idx))
            return wbValue;
        return rfData;
    endfunction

    assign fwdRs1 = forwardOperand(inBundle.rs1, inBundle.rs1Data, heldBundle, heldValid,
                                   wbRegWrite, wbRd, wbData);
    assign fwdRs2 = forwardOperand(inBundle.rs2, inBundle.rs2Data, heldBundle, heldValid,
                                   wbRegWrite, wbRd, wbData);

    assign opA       = fwdRs1;
    assign cmpA      = fwdRs1;
    assign cmpB      = fwdRs2;
    assign storeData = fwdRs2;

    // I-type ops take the immediate instead of rs2
    assign opB = inBundle.aluSrcImm ? inBundle.imm : fwdRs2;

endmodule

`default_nettype wire

//--- common/exPkg.sv
`default_nettype none

package exPkg;

    // Data path word, operands and addresses
    typedef logic [31:0] word_t;

    // Architectural register index, x0 reads as zero
    typedef logic [4:0] regIdx_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluOp_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branchOp_t;

    // Decoded instruction from the ID/EX side
    typedef struct packed {
        word_t     pc;
        word_t     rs1Data;
        word_t     rs2Data;
        word_t     imm;
        regIdx_t   rs1;
        regIdx_t   rs2;
        regIdx_t   rd;
        aluOp_t    aluOp;
        logic      aluSrcImm;
        branchOp_t branchOp;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
    } idExBundle_t;

    // Result handed on to the memory stage
    typedef struct packed {
        word_t   aluResult;
        word_t   storeData;
        word_t   target;
        regIdx_t rd;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    redirect;
    } exMemBundle_t;

endpackage

`default_nettype wire
